//--- build.f
source/decode_pkg.sv
source/opcode_mapper.sv
source/control_rom.sv
source/imm_gen.sv
source/decode_stage.sv
tests/decode_props.sv
tests/decode_tb.sv

//--- tests/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

    localparam int CLK_PERIOD = 4;
    localparam int N_RAND_IMM = 40;  // Random I/load/store words
    localparam int N_BACK     = 30;  // Back-to-back branch and jump words
    localparam int N_RANDOM   = 300; // Fully random words
    localparam int N_TOTAL    = 13 + N_RAND_IMM + 4 + N_BACK + 7 + 5 + N_RANDOM;
    localparam int WATCHDOG_CYCLES = 16 + 2 * N_TOTAL + 100; // Generous margin

    logic                reset;       // Clock
    logic                rst_n;
    logic                instr_valid;
    decode_pkg::instr_u  instr;
    logic                id_valid;
    decode_pkg::id_out_t id_out;

    decode_pkg::id_out_t exp_q[$];    // Expected results in send order
    logic [31:0]         word_q[$];   // Matching instruction words
    decode_pkg::id_out_t last_exp = '0;  // Most recent compared result
    logic [31:0]         last_word = '0;
    logic [31:0]         rng_state = 32'd77;
    int                  n_checks = 0;
    int                  n_errors = 0;
    int                  checks_at_start = 0;
    int                  errors_at_start = 0;

    decode_stage #(.XLEN(decode_pkg::XLEN_MAX)) decode_stage_i (
        .reset       (reset),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .id_valid    (id_valid),
        .id_out      (id_out)
    );

    always #(CLK_PERIOD / 2) reset = ~reset;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Base ALU operation selected by funct3
    function automatic decode_pkg::alu_op_e funct3_op(input logic [2:0] f3);
        case (f3)
            3'd0: return decode_pkg::ALU_ADD;
            3'd1: return decode_pkg::ALU_SLL;
            3'd2: return decode_pkg::ALU_SLT;
            3'd3: return decode_pkg::ALU_SLTU;
            3'd4: return decode_pkg::ALU_XOR;
            3'd5: return decode_pkg::ALU_SRL;
            3'd6: return decode_pkg::ALU_OR;
            default: return decode_pkg::ALU_AND;
        endcase
    endfunction

    function automatic decode_pkg::id_out_t ref_decode(input logic [31:0] w);
        decode_pkg::id_out_t e;
        logic [2:0]          f3;
        logic [6:0]          f7;
        logic [31:0]         imm_i;
        logic                bad;
        e        = '0;
        f3       = w[14:12];
        f7       = w[31:25];
        imm_i    = {{20{w[31]}}, w[31:20]};
        bad      = 1'b0;
        e.rd     = w[11:7];
        e.rs1    = w[19:15];
        e.rs2    = w[24:20];
        e.funct3 = f3;
        e.csr    = w[31:20];
        case (w[6:0])
            7'h33: begin // OP, base and M
                e.ctrl.reg_write = 1'b1;
                e.ctrl.alu_src   = decode_pkg::SRC_REG_REG;
                if (f7 == 7'h00)
                    e.ctrl.alu_op = funct3_op(f3);
                else if (f7 == 7'h20 && f3 == 3'd0)
                    e.ctrl.alu_op = decode_pkg::ALU_SUB;
                else if (f7 == 7'h20 && f3 == 3'd5)
                    e.ctrl.alu_op = decode_pkg::ALU_SRA;
                else if (f7 == 7'h01 && f3 == 3'd0)
                    e.ctrl.alu_op = decode_pkg::ALU_MUL;
                else if (f7 == 7'h01 && f3 == 3'd4)
                    e.ctrl.alu_op = decode_pkg::ALU_OR;  // DIV
                else if (f7 == 7'h01 && f3 == 3'd6)
                    e.ctrl.alu_op = decode_pkg::ALU_AND; // REM
                else
                    bad = 1'b1;
            end
            7'h13: begin // OP-IMM
                e.imm            = imm_i;
                e.ctrl.reg_write = 1'b1;
                e.ctrl.alu_src   = decode_pkg::SRC_REG_IMM;
                e.ctrl.alu_op    = funct3_op(f3);
                if (f3 == 3'd5 && f7 == 7'h20)
                    e.ctrl.alu_op = decode_pkg::ALU_SRA;
                else if ((f3 == 3'd1 || f3 == 3'd5) && f7 != 7'h00)
                    bad = 1'b1; // Bad shift funct7
            end
            7'h03: begin // Load
                e.imm  = imm_i;
                e.ctrl = '{reg_write: 1'b1, mem_to_reg: 1'b1, mem_read: 1'b1,
                           alu_op: decode_pkg::ALU_ADD, alu_src: decode_pkg::SRC_REG_IMM,
                           default: '0};
            end
            7'h23: begin // Store
                e.imm            = {{20{w[31]}}, w[31:25], w[11:7]};
                e.ctrl.mem_write = 1'b1;
                e.ctrl.alu_op    = decode_pkg::ALU_ADD;
                e.ctrl.alu_src   = decode_pkg::SRC_REG_IMM;
            end
            7'h63: begin // Branch
                e.imm          = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                e.ctrl.branch  = 1'b1;
                e.ctrl.alu_op  = decode_pkg::ALU_SUB;
                e.ctrl.alu_src = decode_pkg::SRC_REG_REG;
            end
            7'h37, 7'h17: begin // LUI and AUIPC
                e.imm            = {w[31:12], 12'h000};
                e.ctrl.reg_write = 1'b1;
                e.ctrl.alu_op    = decode_pkg::ALU_ADD;
                e.ctrl.alu_src   = w[5] ? decode_pkg::SRC_REG_IMM : decode_pkg::SRC_PC_IMM;
            end
            7'h6F, 7'h67: begin // JAL and JALR
                e.imm            = w[3] ? {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}
                                        : imm_i;
                e.ctrl.reg_write = 1'b1;
                e.ctrl.alu_op    = decode_pkg::ALU_ADD;
                e.ctrl.alu_src   = w[3] ? decode_pkg::SRC_PC_IMM : decode_pkg::SRC_REG_IMM;
                e.ctrl.rw_sel    = 1'b1;
                e.ctrl.jump      = 1'b1;
            end
            7'h73: begin // SYSTEM
                e.imm            = imm_i;
                e.ctrl.reg_write = 1'b1;
                e.ctrl.alu_src   = f3[2] ? decode_pkg::SRC_REG_IMM : decode_pkg::SRC_REG_REG;
                case (f3[1:0])
                    2'd1: e.ctrl.alu_op = decode_pkg::ALU_XOR; // csrrw(i)
                    2'd2: e.ctrl.alu_op = decode_pkg::ALU_OR;  // csrrs(i)
                    2'd3: e.ctrl.alu_op = decode_pkg::ALU_AND; // csrrc(i)
                    default: begin
                        e.ctrl = '0;
                        if (f3 == 3'd0 && w[31:20] == 12'h302) begin
                            e.ctrl.mret    = 1'b1;
                            e.ctrl.alu_op  = decode_pkg::ALU_XOR;
                            e.ctrl.alu_src = decode_pkg::SRC_REG_REG;
                        end else begin
                            bad = 1'b1; // ecall, ebreak, funct3 4
                        end
                    end
                endcase
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            e.ctrl    = '0;
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    task automatic check_ctrl(input decode_pkg::ctrl_t got, input decode_pkg::ctrl_t exp,
                              input logic [31:0] w);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: id_out.ctrl got 0x%h expected 0x%h (instr 0x%h)", got, exp, w);
        end
    endtask

    task automatic check_imm(input logic [decode_pkg::XLEN_MAX-1:0] got,
                             input logic [decode_pkg::XLEN_MAX-1:0] exp, input logic [31:0] w);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("** Error: id_out.imm got 0x%h expected 0x%h (instr 0x%h)", got, exp, w);
        end
    endtask

    task automatic compare_field(input string name, input logic [11:0] got,
                                 input logic [11:0] exp, input logic [31:0] w);
        if (got !== exp) begin
            n_errors++;
            $display("** Error: %s got 0x%h expected 0x%h (instr 0x%h)", name, got, exp, w);
        end
    endtask

    task automatic check_fields(input decode_pkg::id_out_t got, input decode_pkg::id_out_t exp,
                                input logic [31:0] w);
        n_checks++;
        compare_field("id_out.rd", 12'(got.rd), 12'(exp.rd), w);
        compare_field("id_out.rs1", 12'(got.rs1), 12'(exp.rs1), w);
        compare_field("id_out.rs2", 12'(got.rs2), 12'(exp.rs2), w);
        compare_field("id_out.funct3", 12'(got.funct3), 12'(exp.funct3), w);
        compare_field("id_out.csr", got.csr, exp.csr, w);
        compare_field("id_out.illegal", 12'(got.illegal), 12'(exp.illegal), w);
    endtask

    // Compare on the falling edge, where the register output is settled
    always @(negedge reset) begin : compare_proc
        decode_pkg::id_out_t exp;
        logic [31:0]         w;
        if (rst_n && id_valid) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("Unexpected id_valid with no instruction outstanding");
            end else begin
                exp = exp_q.pop_front();
                w   = word_q.pop_front();
                check_ctrl(id_out.ctrl, exp.ctrl, w);
                check_imm(id_out.imm, exp.imm, w);
                check_fields(id_out, exp, w);
                last_exp  = exp;
                last_word = w;
            end
        end
    end

    task automatic send(input logic [31:0] w);
        @(posedge reset);
        #1;
        instr_valid = 1'b1;
        instr       = w;
        exp_q.push_back(ref_decode(w));
        word_q.push_back(w);
    endtask

    // Random operands, fixed funct7, funct3 and opcode
    task automatic send_encoded(input logic [6:0] f7, input logic [2:0] f3,
                                input logic [6:0] opc);
        logic [31:0] w;
        w = xorshift32();
        w[31:25] = f7;
        w[14:12] = f3;
        w[6:0]   = opc;
        send(w);
    endtask

    task automatic send_opcode(input logic [6:0] opc);
        logic [31:0] w;
        w = xorshift32();
        w[6:0] = opc;
        send(w);
    endtask

    task automatic report_test(input string name);
        @(posedge reset);
        #1;
        instr_valid = 1'b0;
        instr       = xorshift32(); // Idle word must not be captured
        while (exp_q.size() != 0)
            @(negedge reset); // Drain outstanding results
        @(negedge reset);     // Output holds while idle
        check_ctrl(id_out.ctrl, last_exp.ctrl, last_word);
        check_imm(id_out.imm, last_exp.imm, last_word);
        check_fields(id_out, last_exp, last_word);
        $display("Test %-28s %4d checks, %0d errors", name, n_checks - checks_at_start,
                 n_errors - errors_at_start);
        checks_at_start = n_checks;
        errors_at_start = n_errors;
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all decode results arrived");
        $display("Test failures found");
        $finish;
    end

    initial begin : stimulus
        logic [6:0] back_ops[5];
        logic [9:0] r_extra[5];
        logic [2:0] csr_f3[6];
        int         total_errors;
        back_ops = '{7'h63, 7'h37, 7'h17, 7'h6F, 7'h67};
        r_extra  = '{{7'h20, 3'd0}, {7'h20, 3'd5}, {7'h01, 3'd0}, {7'h01, 3'd4}, {7'h01, 3'd6}};
        csr_f3   = '{3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7};
        reset       = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (16) @(posedge reset);
        #1;
        rst_n = 1'b1;

        @(negedge reset); // Idle output after reset
        n_checks++;
        if (id_valid !== 1'b0) begin
            n_errors++;
            $display("** Error: id_valid got 0x%h expected 0x0", id_valid);
        end
        check_ctrl(id_out.ctrl, '0, 32'h0);
        check_imm(id_out.imm, '0, 32'h0);
        check_fields(id_out, '0, 32'h0);
        report_test("reset state");

        for (int f3 = 0; f3 < 8; f3++)
            send_encoded(7'h00, 3'(f3), 7'h33);
        foreach (r_extra[k])
            send_encoded(r_extra[k][9:3], r_extra[k][2:0], 7'h33);
        report_test("R-type and M");

        for (int i = 0; i < N_RAND_IMM; i++)
            send_opcode((i % 3 == 0) ? 7'h13 : (i % 3 == 1) ? 7'h03 : 7'h23);
        send_encoded(7'h00, 3'd1, 7'h13); // slli
        send_encoded(7'h00, 3'd5, 7'h13); // srli
        send_encoded(7'h20, 3'd5, 7'h13); // srai
        send_encoded(7'h20, 3'd1, 7'h13); // Bad slli funct7
        report_test("I-type, load, store");

        for (int i = 0; i < N_BACK; i++)
            send_opcode(back_ops[i % 5]);
        report_test("branch, U-type, jumps");

        foreach (csr_f3[k])
            send_encoded(7'(xorshift32()), csr_f3[k], 7'h73);
        send(32'h3020_0073); // mret
        report_test("CSR and mret");

        send(32'h0000_000F); // fence
        send(32'h0000_0073); // ecall
        send(32'h0010_0073); // ebreak
        send_encoded(7'h20, 3'd1, 7'h33);
        send_opcode(7'h7F);  // Unknown opcode
        for (int i = 0; i < N_RANDOM; i++)
            send(xorshift32());
        report_test("illegal and random");

        total_errors = n_errors + int'(decode_stage_i.decode_props_i.n_fail);
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors,
                 decode_stage_i.decode_props_i.n_fail);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/decode_props.sv
`timescale 1ns/1ps
`default_nettype none

module decode_props (
    input logic              reset,       // Clock
    input logic              rst_n,
    input logic              instr_valid,
    input logic              id_valid,
    input decode_pkg::ctrl_t ctrl,        // Combinational ROM output
    input logic              illegal
);

    int unsigned n_fail = 0; // Failed assertion count

    // Output strobe trails the input strobe by exactly one edge
    assert property (@(posedge reset) disable iff (!rst_n)
                     id_valid == $past(instr_valid))
    else begin
        n_fail++;
        $error("id_valid does not follow instr_valid by one cycle");
    end

    // Trap slot carries no control bits
    assert property (@(posedge reset) disable iff (!rst_n) illegal |-> (ctrl == '0))
    else begin
        n_fail++;
        $error("illegal set with a nonzero control word");
    end

    // Loads always write back from memory
    assert property (@(posedge reset) disable iff (!rst_n)
                     ctrl.mem_read |-> (ctrl.mem_to_reg && ctrl.reg_write))
    else begin
        n_fail++;
        $error("mem_read without mem_to_reg and reg_write");
    end

endmodule

bind decode_stage decode_props decode_props_i (
    .reset       (reset),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .id_valid    (id_valid),
    .ctrl        (ctrl),
    .illegal     (illegal)
);

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int XLEN = 32 // Matches XLEN_MAX of the output struct
) (
    input  logic                reset,       // Clock
    input  logic                rst_n,
    input  logic                instr_valid,
    input  decode_pkg::instr_u  instr,
    output logic                id_valid,
    output decode_pkg::id_out_t id_out
);

    decode_pkg::map_idx_t idx;      // Control store address
    decode_pkg::ctrl_t    ctrl;
    logic                 illegal;
    logic [XLEN-1:0]      imm;
    decode_pkg::id_out_t  id_next;  // Combinational decode result

    opcode_mapper opcode_mapper_i (
        .instr (instr),
        .idx   (idx)
    );

    control_rom control_rom_i (
        .idx     (idx),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

    imm_gen #(
        .XLEN (XLEN)
    ) imm_gen_i (
        .instr (instr),
        .imm   (imm)
    );

    always_comb begin
        id_next         = '0;
        id_next.ctrl    = ctrl;
        id_next.rd      = instr.r.rd;   // Register indices from R view
        id_next.rs1     = instr.r.rs1;
        id_next.rs2     = instr.r.rs2;
        id_next.funct3  = instr.r.funct3;
        id_next.csr     = instr.i.imm;  // CSR address shares I immediate bits
        id_next.imm     = imm;
        id_next.illegal = illegal;
    end

    // Output register, one cycle after the strobe
    always_ff @(posedge reset or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            id_out   <= '0;
        end else begin
            id_valid <= instr_valid;    // Drops when idle
            if (instr_valid)
                id_out <= id_next;      // Holds last value otherwise
        end
    end

endmodule

`default_nettype wire

//--- source/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen #(
    parameter int XLEN = 32
) (
    input  decode_pkg::instr_u instr,
    output logic [XLEN-1:0]    imm
);

    logic [11:0] imm_i; // Raw format immediates
    logic [11:0] imm_s;
    logic [12:0] imm_b;
    logic [31:0] imm_u;
    logic [20:0] imm_j;

    assign imm_i = instr.i.imm;
    assign imm_s = {instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {instr.b.imm12, instr.b.imm11, instr.b.imm10_5,
                    instr.b.imm4_1, 1'b0}; // Halfword offset
    assign imm_u = {instr.u.imm, 12'h000};  // Low 12 bits zero
    assign imm_j = {instr.j.imm20, instr.j.imm19_12, instr.j.imm11,
                    instr.j.imm10_1, 1'b0};

    always_comb begin
        case (instr.r.opcode) // Format follows opcode
            decode_pkg::OPC_OP_IMM,
            decode_pkg::OPC_LOAD,
            decode_pkg::OPC_JALR,
            decode_pkg::OPC_SYSTEM: imm = XLEN'($signed(imm_i)); // CSR forms too
            decode_pkg::OPC_STORE:  imm = XLEN'($signed(imm_s));
            decode_pkg::OPC_BRANCH: imm = XLEN'($signed(imm_b));
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC:  imm = XLEN'($signed(imm_u));
            decode_pkg::OPC_JAL:    imm = XLEN'($signed(imm_j));
            default:                imm = '0; // R-type and unknown
        endcase
    end

endmodule

`default_nettype wire

//--- source/control_rom.sv
`timescale 1ns/1ps
`default_nettype none

module control_rom (
    input  decode_pkg::map_idx_t idx,
    output decode_pkg::ctrl_t    ctrl,
    output logic                 illegal
);

    // Register-writing ALU row
    function automatic decode_pkg::ctrl_t alu_row(decode_pkg::alu_op_e  op,
                                                  decode_pkg::alu_src_t src);
        decode_pkg::ctrl_t c;
        c           = '0;
        c.reg_write = 1'b1;
        c.alu_op    = op;
        c.alu_src   = src;
        return c;
    endfunction

    always_comb begin
        ctrl = '0; // Index 0 and unused slots
        case (idx)
            decode_pkg::IDX_ADD:    ctrl = alu_row(decode_pkg::ALU_ADD,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_SUB:    ctrl = alu_row(decode_pkg::ALU_SUB,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_AND:    ctrl = alu_row(decode_pkg::ALU_AND,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_OR:     ctrl = alu_row(decode_pkg::ALU_OR,   decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_XOR:    ctrl = alu_row(decode_pkg::ALU_XOR,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_SLL:    ctrl = alu_row(decode_pkg::ALU_SLL,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_SRL:    ctrl = alu_row(decode_pkg::ALU_SRL,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_SRA:    ctrl = alu_row(decode_pkg::ALU_SRA,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_SLT:    ctrl = alu_row(decode_pkg::ALU_SLT,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_SLTU:   ctrl = alu_row(decode_pkg::ALU_SLTU, decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_LOAD: begin // Address is rs1 + imm
                ctrl            = alu_row(decode_pkg::ALU_ADD, decode_pkg::SRC_REG_IMM);
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
            end
            decode_pkg::IDX_STORE: begin // No writeback
                ctrl.mem_write = 1'b1;
                ctrl.alu_op    = decode_pkg::ALU_ADD;
                ctrl.alu_src   = decode_pkg::SRC_REG_IMM;
            end
            decode_pkg::IDX_BRANCH: begin // Compare by subtract
                ctrl.branch  = 1'b1;
                ctrl.alu_op  = decode_pkg::ALU_SUB;
                ctrl.alu_src = decode_pkg::SRC_REG_REG;
            end
            decode_pkg::IDX_ADDI:   ctrl = alu_row(decode_pkg::ALU_ADD,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_SLTI:   ctrl = alu_row(decode_pkg::ALU_SLT,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_SLTIU:  ctrl = alu_row(decode_pkg::ALU_SLTU, decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_XORI:   ctrl = alu_row(decode_pkg::ALU_XOR,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_ORI:    ctrl = alu_row(decode_pkg::ALU_OR,   decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_ANDI:   ctrl = alu_row(decode_pkg::ALU_AND,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_SLLI:   ctrl = alu_row(decode_pkg::ALU_SLL,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_SRLI:   ctrl = alu_row(decode_pkg::ALU_SRL,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_SRAI:   ctrl = alu_row(decode_pkg::ALU_SRA,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_LUI:    ctrl = alu_row(decode_pkg::ALU_ADD,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_AUIPC:  ctrl = alu_row(decode_pkg::ALU_ADD,  decode_pkg::SRC_PC_IMM);
            decode_pkg::IDX_JAL: begin // Target PC + imm, link PC+4
                ctrl        = alu_row(decode_pkg::ALU_ADD, decode_pkg::SRC_PC_IMM);
                ctrl.rw_sel = 1'b1;
                ctrl.jump   = 1'b1;
            end
            decode_pkg::IDX_JALR: begin // Target rs1 + imm
                ctrl        = alu_row(decode_pkg::ALU_ADD, decode_pkg::SRC_REG_IMM);
                ctrl.rw_sel = 1'b1;
                ctrl.jump   = 1'b1;
            end
            decode_pkg::IDX_MUL:    ctrl = alu_row(decode_pkg::ALU_MUL,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_DIV:    ctrl = alu_row(decode_pkg::ALU_OR,   decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_REM:    ctrl = alu_row(decode_pkg::ALU_AND,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_CSRRW:  ctrl = alu_row(decode_pkg::ALU_XOR,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_CSRRC:  ctrl = alu_row(decode_pkg::ALU_AND,  decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_CSRRS:  ctrl = alu_row(decode_pkg::ALU_OR,   decode_pkg::SRC_REG_REG);
            decode_pkg::IDX_CSRRWI: ctrl = alu_row(decode_pkg::ALU_XOR,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_CSRRSI: ctrl = alu_row(decode_pkg::ALU_OR,   decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_CSRRCI: ctrl = alu_row(decode_pkg::ALU_AND,  decode_pkg::SRC_REG_IMM);
            decode_pkg::IDX_MRET: begin // No writeback
                ctrl.mret    = 1'b1;
                ctrl.alu_op  = decode_pkg::ALU_XOR;
                ctrl.alu_src = decode_pkg::SRC_REG_REG;
            end
            default: ctrl = '0; // Includes the trap slot
        endcase
    end

    assign illegal = (idx == decode_pkg::IDX_ILLEGAL); // Trap slot only

endmodule

`default_nettype wire

//--- source/opcode_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module opcode_mapper (
    input  decode_pkg::instr_u   instr,
    output decode_pkg::map_idx_t idx
);

    always_comb begin
        idx = decode_pkg::IDX_ILLEGAL; // Anything unmatched traps
        case (instr.r.opcode)
            decode_pkg::OPC_OP: begin
                if (instr.r.funct7 == 7'b0000000) begin // Base ALU ops
                    case (instr.r.funct3)
                        3'd0: idx = decode_pkg::IDX_ADD;
                        3'd1: idx = decode_pkg::IDX_SLL;
                        3'd2: idx = decode_pkg::IDX_SLT;
                        3'd3: idx = decode_pkg::IDX_SLTU;
                        3'd4: idx = decode_pkg::IDX_XOR;
                        3'd5: idx = decode_pkg::IDX_SRL;
                        3'd6: idx = decode_pkg::IDX_OR;
                        default: idx = decode_pkg::IDX_AND;
                    endcase
                end else if (instr.r.funct7 == 7'b0100000) begin // SUB and SRA only
                    case (instr.r.funct3)
                        3'd0: idx = decode_pkg::IDX_SUB;
                        3'd5: idx = decode_pkg::IDX_SRA;
                        default: idx = decode_pkg::IDX_ILLEGAL;
                    endcase
                end else if (instr.r.funct7 == 7'b0000001) begin // M extension subset
                    case (instr.r.funct3)
                        3'd0: idx = decode_pkg::IDX_MUL;
                        3'd4: idx = decode_pkg::IDX_DIV;
                        3'd6: idx = decode_pkg::IDX_REM;
                        default: idx = decode_pkg::IDX_ILLEGAL; // MULH*, DIVU, REMU
                    endcase
                end
            end
            decode_pkg::OPC_OP_IMM: begin
                case (instr.i.funct3)
                    3'd0: idx = decode_pkg::IDX_ADDI;
                    3'd2: idx = decode_pkg::IDX_SLTI;
                    3'd3: idx = decode_pkg::IDX_SLTIU;
                    3'd4: idx = decode_pkg::IDX_XORI;
                    3'd6: idx = decode_pkg::IDX_ORI;
                    3'd7: idx = decode_pkg::IDX_ANDI;
                    3'd1: begin
                        if (instr.i.imm[11:5] == 7'b0000000) // Shift funct7 must be clear
                            idx = decode_pkg::IDX_SLLI;
                    end
                    default: begin // funct3 5, logical or arithmetic
                        if (instr.i.imm[11:5] == 7'b0000000)
                            idx = decode_pkg::IDX_SRLI;
                        else if (instr.i.imm[11:5] == 7'b0100000)
                            idx = decode_pkg::IDX_SRAI;
                    end
                endcase
            end
            decode_pkg::OPC_LOAD:   idx = decode_pkg::IDX_LOAD;   // Width left to memory
            decode_pkg::OPC_STORE:  idx = decode_pkg::IDX_STORE;
            decode_pkg::OPC_BRANCH: idx = decode_pkg::IDX_BRANCH; // Condition from funct3
            decode_pkg::OPC_LUI:    idx = decode_pkg::IDX_LUI;
            decode_pkg::OPC_AUIPC:  idx = decode_pkg::IDX_AUIPC;
            decode_pkg::OPC_JAL:    idx = decode_pkg::IDX_JAL;
            decode_pkg::OPC_JALR:   idx = decode_pkg::IDX_JALR;
            decode_pkg::OPC_SYSTEM: begin
                case (instr.i.funct3)
                    3'd1: idx = decode_pkg::IDX_CSRRW;
                    3'd2: idx = decode_pkg::IDX_CSRRS;
                    3'd3: idx = decode_pkg::IDX_CSRRC;
                    3'd5: idx = decode_pkg::IDX_CSRRWI;
                    3'd6: idx = decode_pkg::IDX_CSRRSI;
                    3'd7: idx = decode_pkg::IDX_CSRRCI;
                    3'd0: begin
                        if (instr.i.imm == 12'h302) // mret; ecall and ebreak trap
                            idx = decode_pkg::IDX_MRET;
                    end
                    default: idx = decode_pkg::IDX_ILLEGAL;
                endcase
            end
            default: idx = decode_pkg::IDX_ILLEGAL; // Includes fence
        endcase
    end

endmodule

`default_nettype wire

//--- source/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int XLEN_MAX = 32; // Widest immediate carried downstream

    // Major opcodes, bits [6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_AND  = 4'd0,
        ALU_OR   = 4'd1,
        ALU_ADD  = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_SLL  = 4'd4,
        ALU_SRL  = 4'd5,
        ALU_SUB  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_MUL  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_NONE    = 2'b00, // Empty rows only
        SRC_PC_IMM  = 2'b01, // PC and immediate
        SRC_REG_REG = 2'b10, // rs1 and rs2
        SRC_REG_IMM = 2'b11  // rs1 and immediate
    } alu_src_t;

    typedef struct packed {
        logic     mret;       // Return from trap
        logic     reg_write;  // Write rd
        logic     mem_to_reg; // Writeback from memory
        logic     mem_read;
        logic     mem_write;
        alu_op_e  alu_op;
        alu_src_t alu_src;
        logic     rw_sel;     // Writeback PC+4
        logic     branch;
        logic     jump;
    } ctrl_t; // 14 bits

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;     // Also CSR address
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;     // Bits 31:12 of result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef logic [5:0] map_idx_t; // Control store address

    localparam map_idx_t IDX_ADD     = 6'd1;
    localparam map_idx_t IDX_SUB     = 6'd2;
    localparam map_idx_t IDX_AND     = 6'd3;
    localparam map_idx_t IDX_OR      = 6'd4;
    localparam map_idx_t IDX_XOR     = 6'd5;
    localparam map_idx_t IDX_SLL     = 6'd6;
    localparam map_idx_t IDX_SRL     = 6'd7;
    localparam map_idx_t IDX_SRA     = 6'd8;
    localparam map_idx_t IDX_SLT     = 6'd9;
    localparam map_idx_t IDX_SLTU    = 6'd10;
    localparam map_idx_t IDX_LOAD    = 6'd11;
    localparam map_idx_t IDX_STORE   = 6'd12;
    localparam map_idx_t IDX_BRANCH  = 6'd13;
    localparam map_idx_t IDX_ADDI    = 6'd14;
    localparam map_idx_t IDX_SLTI    = 6'd15;
    localparam map_idx_t IDX_SLTIU   = 6'd16;
    localparam map_idx_t IDX_XORI    = 6'd17;
    localparam map_idx_t IDX_ORI     = 6'd18;
    localparam map_idx_t IDX_ANDI    = 6'd19;
    localparam map_idx_t IDX_SLLI    = 6'd20;
    localparam map_idx_t IDX_SRLI    = 6'd21;
    localparam map_idx_t IDX_SRAI    = 6'd22;
    localparam map_idx_t IDX_LUI     = 6'd23;
    localparam map_idx_t IDX_AUIPC   = 6'd24;
    localparam map_idx_t IDX_JAL     = 6'd25;
    localparam map_idx_t IDX_JALR    = 6'd26;
    localparam map_idx_t IDX_MUL     = 6'd27;
    localparam map_idx_t IDX_DIV     = 6'd28;
    localparam map_idx_t IDX_REM     = 6'd29;
    localparam map_idx_t IDX_CSRRW   = 6'd30;
    localparam map_idx_t IDX_CSRRC   = 6'd31;
    localparam map_idx_t IDX_CSRRS   = 6'd32;
    localparam map_idx_t IDX_CSRRWI  = 6'd33;
    localparam map_idx_t IDX_CSRRSI  = 6'd34;
    localparam map_idx_t IDX_CSRRCI  = 6'd35;
    localparam map_idx_t IDX_MRET    = 6'd36;
    localparam map_idx_t IDX_ILLEGAL = 6'd63; // Trap slot

    typedef struct packed {
        ctrl_t               ctrl;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [2:0]          funct3;
        logic [11:0]         csr;     // CSR address field
        logic [XLEN_MAX-1:0] imm;     // Sign-extended immediate
        logic                illegal;
    } id_out_t;

endpackage

`default_nettype wire
